// File: build.f
+incdir+verification
common/sad_pkg.sv
sad_core/sad_lane.sv
sad_core/sad_engine.sv
logic/sad_regs.sv
logic/sad_control.sv
logic/sad_trigger.sv
verification/tb_sad_trigger.sv

// File: common/sad_pkg.sv
package sad_pkg;

    // register map
    localparam logic [7:0] addr_reference         = 8'd0;
    localparam logic [7:0] addr_threshold         = 8'd1;
    localparam logic [7:0] addr_status            = 8'd2;
    localparam logic [7:0] addr_bits_per_sample   = 8'd3;
    localparam logic [7:0] addr_ref_samples       = 8'd4;
    localparam logic [7:0] addr_multiple_triggers = 8'd5;

    // threshold and lane sums share this width
    localparam int threshold_width = 32;

    // one access on the register bus
    typedef struct packed {
        logic [7:0] address;
        logic [7:0] bytecnt;  // byte index, lsb first
        logic [7:0] wdata;
        logic       read;
        logic       write;
    } reg_bus_t;

    // sequencer states
    typedef enum logic [1:0] {
        st_idle         = 2'd0,
        st_initializing = 2'd1,
        st_running      = 2'd2,
        st_flush        = 2'd3
    } sad_state_e;

endpackage

// File: logic/sad_control.sv
module sad_control #(
    parameter int ref_samples = 8
) (
    input  logic                   reset,
    input  logic                   adc_sampleclk,
    input  logic                   armed_and_ready,
    input  logic                   active,
    input  logic                   multiple_triggers,
    input  logic                   clear_status,
    input  logic                   any_hit,
    output logic [ref_samples-1:0] lane_enable,
    output logic                   trigger
);

    localparam int cnt_width = (ref_samples > 1) ? $clog2(ref_samples) : 1;
    localparam logic [cnt_width-1:0] last_lane = cnt_width'(ref_samples - 1);

    sad_pkg::sad_state_e    state;
    logic [cnt_width-1:0]   start_cnt;  // next lane to start

    always_ff @(posedge adc_sampleclk) begin
        if (reset) begin
            state       <= sad_pkg::st_idle;
            start_cnt   <= '0;
            lane_enable <= '0;
            trigger     <= 1'b0;
        end else begin
            case (state)
                sad_pkg::st_idle: begin
                    start_cnt   <= '0;
                    lane_enable <= '0;
                    trigger     <= 1'b0;
                    if (armed_and_ready && active)
                        state <= sad_pkg::st_initializing;
                end

                sad_pkg::st_initializing: begin
                    // one lane per cycle, each lane owns one window phase
                    lane_enable[start_cnt] <= 1'b1;
                    start_cnt <= start_cnt + 1'b1;
                    trigger   <= 1'b0;
                    if (start_cnt == last_lane)
                        state <= sad_pkg::st_running;
                end

                sad_pkg::st_running: begin
                    if (!active) begin
                        trigger <= 1'b0;
                        state   <= sad_pkg::st_flush;
                    end else begin
                        trigger <= any_hit;
                        if (any_hit && !multiple_triggers)
                            state <= sad_pkg::st_flush;  // single shot done
                    end
                end

                sad_pkg::st_flush: begin
                    trigger     <= 1'b0;
                    lane_enable <= '0;  // let the lane pipelines drain
                    if (!armed_and_ready || clear_status)
                        state <= sad_pkg::st_idle;
                end
            endcase
        end
    end

endmodule

// File: logic/sad_regs.sv
module sad_regs #(
    parameter int ref_samples     = 8,
    parameter int bits_per_sample = 8
) (
    input  logic                                    reset,
    input  logic                                    adc_sampleclk,
    input  sad_pkg::reg_bus_t                       bus,
    input  logic                                    trigger,
    output logic [7:0]                              rdata,
    output logic [ref_samples*bits_per_sample-1:0]  reference,
    output logic [sad_pkg::threshold_width-1:0]     threshold,
    output logic                                    multiple_triggers,
    output logic                                    clear_status
);

    // reference storage rounded up to whole bytes
    localparam int ref_bytes = (ref_samples * bits_per_sample + 7) / 8;
    localparam int thr_bytes = sad_pkg::threshold_width / 8;

    logic [ref_bytes*8-1:0] ref_q;
    logic                   triggered;  // sticky
    logic                   ref_in_range;
    logic                   thr_in_range;

    assign ref_in_range = (bus.bytecnt < ref_bytes);
    assign thr_in_range = (bus.bytecnt < thr_bytes);

    assign reference = ref_q[ref_samples*bits_per_sample-1:0];

    // any write to status clears it
    assign clear_status = bus.write && (bus.address == sad_pkg::addr_status);

    always_ff @(posedge adc_sampleclk) begin
        if (reset) begin
            ref_q             <= '0;
            threshold         <= '0;
            multiple_triggers <= 1'b0;
        end else if (bus.write) begin
            case (bus.address)
                sad_pkg::addr_reference: begin
                    if (ref_in_range)
                        ref_q[bus.bytecnt*8 +: 8] <= bus.wdata;
                end
                sad_pkg::addr_threshold: begin
                    if (thr_in_range)
                        threshold[bus.bytecnt*8 +: 8] <= bus.wdata;
                end
                sad_pkg::addr_multiple_triggers: multiple_triggers <= bus.wdata[0];
                default: ;
            endcase
        end
    end

    always_ff @(posedge adc_sampleclk) begin
        if (reset)
            triggered <= 1'b0;
        else if (clear_status)
            triggered <= 1'b0;  // clear beats a simultaneous trigger
        else if (trigger)
            triggered <= 1'b1;
    end

    always_comb begin
        rdata = 8'h00;
        if (bus.read) begin
            case (bus.address)
                sad_pkg::addr_reference: begin
                    if (ref_in_range)
                        rdata = ref_q[bus.bytecnt*8 +: 8];
                end
                sad_pkg::addr_threshold: begin
                    if (thr_in_range)
                        rdata = threshold[bus.bytecnt*8 +: 8];
                end
                sad_pkg::addr_status:            rdata = {7'b0, triggered};
                sad_pkg::addr_bits_per_sample:   rdata = 8'(bits_per_sample);
                sad_pkg::addr_ref_samples:       rdata = 8'(ref_samples);
                sad_pkg::addr_multiple_triggers: rdata = {7'b0, multiple_triggers};
                default:                         rdata = 8'h00;
            endcase
        end
    end

endmodule

// File: logic/sad_trigger.sv
module sad_trigger #(
    parameter int ref_samples     = 8,
    parameter int bits_per_sample = 8
) (
    input  logic                        reset,
    input  logic                        adc_sampleclk,
    input  logic [bits_per_sample-1:0]  adc_datain,
    input  logic                        armed_and_ready,
    input  logic                        active,
    input  sad_pkg::reg_bus_t           bus,
    output logic [7:0]                  rdata,
    output logic                        trigger
);

    logic [ref_samples*bits_per_sample-1:0] reference;
    logic [sad_pkg::threshold_width-1:0]    threshold;
    logic                                   multiple_triggers;
    logic                                   clear_status;
    logic [ref_samples-1:0]                 lane_enable;
    logic                                   any_hit;

    sad_regs #(
        .ref_samples     (ref_samples),
        .bits_per_sample (bits_per_sample)
    ) u_regs (
        .reset             (reset),
        .adc_sampleclk     (adc_sampleclk),
        .bus               (bus),
        .trigger           (trigger),
        .rdata             (rdata),
        .reference         (reference),
        .threshold         (threshold),
        .multiple_triggers (multiple_triggers),
        .clear_status      (clear_status)
    );

    sad_control #(
        .ref_samples (ref_samples)
    ) u_control (
        .reset             (reset),
        .adc_sampleclk     (adc_sampleclk),
        .armed_and_ready   (armed_and_ready),
        .active            (active),
        .multiple_triggers (multiple_triggers),
        .clear_status      (clear_status),
        .any_hit           (any_hit),
        .lane_enable       (lane_enable),
        .trigger           (trigger)
    );

    sad_engine #(
        .ref_samples     (ref_samples),
        .bits_per_sample (bits_per_sample)
    ) u_engine (
        .reset         (reset),
        .adc_sampleclk (adc_sampleclk),
        .adc_datain    (adc_datain),
        .reference     (reference),
        .threshold     (threshold),
        .lane_enable   (lane_enable),
        .any_hit       (any_hit)
    );

endmodule

// File: run_sim.sh
#!/bin/sh
# build and run the SAD trigger testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --timescale 1ns/100ps \
    --top-module tb_sad_trigger -f build.f -o tb_sad_trigger

./obj_dir/tb_sad_trigger | tee sim.log

if grep -qx "No errors" sim.log; then
    echo "simulation passed"
    exit 0
fi
echo "simulation failed, see sim.log"
exit 1

// File: sad_core/sad_engine.sv
module sad_engine #(
    parameter int ref_samples     = 8,
    parameter int bits_per_sample = 8
) (
    input  logic                                    reset,
    input  logic                                    adc_sampleclk,
    input  logic [bits_per_sample-1:0]              adc_datain,
    input  logic [ref_samples*bits_per_sample-1:0]  reference,
    input  logic [sad_pkg::threshold_width-1:0]     threshold,
    input  logic [ref_samples-1:0]                  lane_enable,
    output logic                                    any_hit
);

    logic [bits_per_sample-1:0] sample_r;  // shared by every lane
    logic [ref_samples-1:0]     lane_hit;

    always_ff @(posedge adc_sampleclk) begin
        if (reset)
            sample_r <= '0;
        else
            sample_r <= adc_datain;
    end

    // lane i sees windows starting at sample i, i+ref_samples, ...
    generate
        for (genvar i = 0; i < ref_samples; i++) begin : gen_lane
            sad_lane #(
                .ref_samples     (ref_samples),
                .bits_per_sample (bits_per_sample)
            ) u_lane (
                .adc_sampleclk (adc_sampleclk),
                .enable        (lane_enable[i]),
                .sample        (sample_r),
                .reference     (reference),
                .threshold     (threshold),
                .hit           (lane_hit[i])
            );
        end
    endgenerate

    assign any_hit = |lane_hit;

endmodule

// File: sad_core/sad_lane.sv
module sad_lane #(
    parameter int ref_samples     = 8,
    parameter int bits_per_sample = 8
) (
    input  logic                                    adc_sampleclk,
    input  logic                                    enable,
    input  logic [bits_per_sample-1:0]              sample,
    input  logic [ref_samples*bits_per_sample-1:0]  reference,
    input  logic [sad_pkg::threshold_width-1:0]     threshold,
    output logic                                    hit
);

    localparam int phase_width = (ref_samples > 1) ? $clog2(ref_samples) : 1;
    localparam logic [phase_width-1:0] last_phase = phase_width'(ref_samples - 1);

    logic [phase_width-1:0]              phase;
    logic [bits_per_sample-1:0]          ref_sample;
    logic [bits_per_sample-1:0]          abs_diff;
    logic                                diff_valid;
    logic                                diff_first;
    logic                                diff_last;
    logic [sad_pkg::threshold_width-1:0] sum;
    logic [sad_pkg::threshold_width-1:0] sum_next;

    // reference sample for the current window position
    assign ref_sample = reference[phase*bits_per_sample +: bits_per_sample];

    always_ff @(posedge adc_sampleclk) begin
        if (!enable)
            phase <= '0;  // lane idle, restart on next enable
        else if (phase == last_phase)
            phase <= '0;
        else
            phase <= phase + 1'b1;
    end

    // stage 1, absolute difference
    always_ff @(posedge adc_sampleclk) begin
        diff_valid <= enable;
        diff_first <= enable && (phase == '0);
        diff_last  <= enable && (phase == last_phase);
        if (sample > ref_sample)
            abs_diff <= sample - ref_sample;
        else
            abs_diff <= ref_sample - sample;
    end

    // first sample of a window starts a fresh sum
    assign sum_next = (diff_first ? '0 : sum) + sad_pkg::threshold_width'(abs_diff);

    // stage 2, accumulate and compare
    always_ff @(posedge adc_sampleclk) begin
        if (diff_valid)
            sum <= sum_next;
        hit <= diff_valid && diff_last && (sum_next <= threshold);
    end

endmodule

// File: verification/tb_sad_vectors.svh
`ifndef TB_SAD_VECTORS_SVH
`define TB_SAD_VECTORS_SVH

// one test case, applied by run_case
typedef struct packed {
    logic [31:0] ref_seed;         // seed of the reference pattern
    logic [31:0] threshold;
    logic        multiple;         // multiple_triggers register
    logic [15:0] splice_a;         // first stream index of the reference copy
    logic [7:0]  offset_a;         // added to every spliced sample
    logic [15:0] splice_b;
    logic [7:0]  offset_b;
    logic [15:0] stream_len;
    logic [15:0] active_len;       // active drops at this stream index
    logic [7:0]  exp_count;        // trigger pulses expected
    logic        clear_by_status;  // leave flush through a status write
} test_case_t;

localparam int num_cases = 5;
localparam logic [15:0] no_splice = 16'hffff;

// single shot exact match, then clear via status
// multiple mode, offsets 1 and 3 (SAD 8 and 24) against threshold 16
// multiple mode, two hits at threshold 8, windows 9 samples apart
// active drops before the second exact match
// single shot with two exact matches, only the first fires
localparam test_case_t case_table [num_cases] = '{
    '{32'h1234_5678, 32'd0, 1'b0, 16'd20, 8'd0, no_splice, 8'd0,
      16'd60, 16'd60, 8'd1, 1'b1},
    '{32'h0bad_cafe, 32'd16, 1'b1, 16'd14, 8'd1, 16'd40, 8'd3,
      16'd64, 16'd64, 8'd1, 1'b0},
    '{32'h5eed_0002, 32'd8, 1'b1, 16'd10, 8'd1, 16'd19, 8'd1,
      16'd48, 16'd48, 8'd2, 1'b0},
    '{32'h0000_0abc, 32'd0, 1'b1, 16'd10, 8'd0, 16'd40, 8'd0,
      16'd56, 16'd30, 8'd1, 1'b1},
    '{32'h0000_7777, 32'd0, 1'b0, 16'd10, 8'd0, 16'd30, 8'd0,
      16'd50, 16'd50, 8'd1, 1'b0}
};

`endif

// File: verification/tb_sad_trigger.sv
module tb_sad_trigger;
    timeunit 1ns;
    timeprecision 100ps;

    `include "tb_sad_vectors.svh"

    localparam int window_len   = 8;
    localparam int trig_latency = 4;    // sample reg, abs diff, sum, trigger reg
    localparam int max_len      = 128;
    localparam int row_overhead = 80;   // bus setup, readback and teardown per row

    logic               reset;
    logic               adc_sampleclk;
    logic [7:0]         adc_datain;
    logic               armed_and_ready;
    logic               active;
    sad_pkg::reg_bus_t  bus;
    logic [7:0]         rdata;
    logic               trigger;

    logic [7:0]  stream [0:max_len-1];
    logic [7:0]  ref_pat [0:window_len-1];
    logic        exp_trig [0:max_len+window_len-1];
    logic [31:0] stream_state;
    logic        in_stream;
    int          errors;
    int          checks;

    sad_trigger u_dut (
        .reset           (reset),
        .adc_sampleclk   (adc_sampleclk),
        .adc_datain      (adc_datain),
        .armed_and_ready (armed_and_ready),
        .active          (active),
        .bus             (bus),
        .rdata           (rdata),
        .trigger         (trigger)
    );

    initial begin
        adc_sampleclk = 1'b0;
        forever #5 adc_sampleclk = ~adc_sampleclk;
    end

    function automatic logic [31:0] lcg_next(input logic [31:0] state);
        return state * 32'd1103515245 + 32'd12345;
    endfunction

    function automatic int timeout_cycles();
        int total;
        total = 200;
        for (int i = 0; i < num_cases; i++)
            total += int'(case_table[i].stream_len) + row_overhead;
        return total;
    endfunction

    task automatic write_reg(input logic [7:0] addr, input logic [7:0] idx,
                             input logic [7:0] data);
        sad_pkg::reg_bus_t acc;
        acc = '0;
        acc.address = addr;
        acc.bytecnt = idx;
        acc.wdata = data;
        acc.write = 1'b1;
        @(posedge adc_sampleclk);
        bus <= acc;
        @(posedge adc_sampleclk);  // write lands here
        bus <= '0;
    endtask

    task automatic check_reg(input logic [7:0] addr, input logic [7:0] idx,
                             input logic [7:0] expected, input string name);
        sad_pkg::reg_bus_t acc;
        logic [7:0]        got;
        acc = '0;
        acc.address = addr;
        acc.bytecnt = idx;
        acc.read = 1'b1;
        @(posedge adc_sampleclk);
        bus <= acc;
        @(negedge adc_sampleclk);
        got = rdata;
        checks++;
        if (got !== expected) begin
            errors++;
            $display("[ERROR] rdata %s[%0d]: got %h, expected %h", name, idx, got, expected);
        end
        @(posedge adc_sampleclk);
        bus <= '0;
    endtask

    task automatic check_reset_values();
        for (int k = 0; k <= window_len; k++)   // one byte past the end reads 0 too
            check_reg(sad_pkg::addr_reference, 8'(k), 8'h00, "reference");
        for (int k = 0; k < 4; k++)
            check_reg(sad_pkg::addr_threshold, 8'(k), 8'h00, "threshold");
        check_reg(sad_pkg::addr_status, 8'h00, 8'h00, "status");
        check_reg(sad_pkg::addr_bits_per_sample, 8'h00, 8'h08, "bits_per_sample");
        check_reg(sad_pkg::addr_ref_samples, 8'h00, 8'h08, "ref_samples");
        check_reg(sad_pkg::addr_multiple_triggers, 8'h00, 8'h00, "multiple_triggers");
        check_reg(8'h06, 8'h00, 8'h00, "unused");
    endtask

    task automatic splice_reference(input logic [15:0] at, input logic [7:0] offset,
                                    input int len);
        int base;
        base = int'(at);
        if (at != no_splice && base + window_len <= len) begin
            for (int k = 0; k < window_len; k++)
                stream[base + k] = ref_pat[k] + offset;
        end
    endtask

    // SAD rule over every complete window, trigger expected trig_latency after its end
    task automatic predict_triggers(input logic [31:0] thr, input logic mult,
                                    input int len, input int act_len, output int count);
        logic [31:0] sad;
        logic [7:0]  a;
        logic [7:0]  b;
        count = 0;
        for (int c = 0; c < max_len + window_len; c++)
            exp_trig[c] = 1'b0;
        for (int j = window_len - 1; j < len; j++) begin
            sad = '0;
            for (int k = 0; k < window_len; k++) begin
                a = stream[j - window_len + 1 + k];
                b = ref_pat[k];
                sad = sad + ((a > b) ? {24'd0, a - b} : {24'd0, b - a});
            end
            // nothing fires once active is low or a single shot is spent
            if (sad <= thr && j + trig_latency <= act_len && (mult || count == 0)) begin
                exp_trig[j + trig_latency] = 1'b1;
                count++;
            end
        end
    endtask

    task automatic run_case(input int idx);
        test_case_t  tc;
        logic [31:0] st;
        int          len;
        int          act_len;
        int          model_count;
        int          pulses;
        tc = case_table[idx];
        len = int'(tc.stream_len);
        act_len = int'(tc.active_len);
        pulses = 0;

        st = tc.ref_seed;
        for (int k = 0; k < window_len; k++) begin
            st = lcg_next(st);
            ref_pat[k] = (st[23:16] % 8'd224) + 8'd16;  // room for offsets
        end
        for (int n = 0; n < len; n++) begin
            stream_state = lcg_next(stream_state);
            stream[n] = stream_state[23:16];
        end
        splice_reference(tc.splice_a, tc.offset_a, len);
        splice_reference(tc.splice_b, tc.offset_b, len);
        predict_triggers(tc.threshold, tc.multiple, len, act_len, model_count);
        if (model_count != int'(tc.exp_count)) begin
            errors++;
            $display("row %0d: the reference model predicts %0d triggers, the table lists %0d",
                     idx, model_count, tc.exp_count);
        end

        for (int k = 0; k < 4; k++)
            write_reg(sad_pkg::addr_threshold, 8'(k), tc.threshold[k*8 +: 8]);
        for (int k = 0; k < window_len; k++)
            write_reg(sad_pkg::addr_reference, 8'(k), ref_pat[k]);
        write_reg(sad_pkg::addr_multiple_triggers, 8'h00, {7'b0, tc.multiple});
        for (int k = 0; k < 4; k++)
            check_reg(sad_pkg::addr_threshold, 8'(k), tc.threshold[k*8 +: 8], "threshold");
        for (int k = 0; k < window_len; k++)
            check_reg(sad_pkg::addr_reference, 8'(k), ref_pat[k], "reference");
        check_reg(sad_pkg::addr_multiple_triggers, 8'h00, {7'b0, tc.multiple},
                  "multiple_triggers");

        @(posedge adc_sampleclk);
        armed_and_ready <= 1'b1;
        active <= 1'b1;
        in_stream = 1'b1;
        // first pass is edge E0, sample 0 is present at E0+1
        for (int c = 0; c < len + trig_latency; c++) begin
            @(posedge adc_sampleclk);
            if (c < len)
                adc_datain <= stream[c];
            else
                adc_datain <= 8'h00;
            if (c == act_len)
                active <= 1'b0;
            @(negedge adc_sampleclk);
            checks++;
            if (trigger !== exp_trig[c]) begin
                errors++;
                $display("[ERROR] trigger row %0d cycle %0d: got %h, expected %h",
                         idx, c, trigger, exp_trig[c]);
            end
            if (trigger === 1'b1)
                pulses++;
        end
        in_stream = 1'b0;
        checks++;
        if (pulses != model_count) begin
            errors++;
            $display("[ERROR] trigger pulses row %0d: got %h, expected %h",
                     idx, pulses, model_count);
        end

        @(posedge adc_sampleclk);
        active <= 1'b0;  // stream over, the next row arms from idle
        @(posedge adc_sampleclk);
        check_reg(sad_pkg::addr_status, 8'h00, (model_count > 0) ? 8'h01 : 8'h00, "status");
        if (tc.clear_by_status) begin
            // armed stays high, the status write alone must reach idle
            write_reg(sad_pkg::addr_status, 8'h00, 8'h00);
        end else begin
            @(posedge adc_sampleclk);
            armed_and_ready <= 1'b0;
            write_reg(sad_pkg::addr_status, 8'h00, 8'h00);
        end
        check_reg(sad_pkg::addr_status, 8'h00, 8'h00, "status");
    endtask

    always @(negedge adc_sampleclk) begin
        if (!reset && !in_stream) begin
            if (trigger !== 1'b0) begin
                errors++;
                $display("[ERROR] trigger outside a stream: got %h, expected %h",
                         trigger, 1'b0);
            end
        end
    end

    initial begin : watchdog
        int limit;
        int cycles;
        limit = timeout_cycles();
        cycles = 0;
        while (cycles < limit) begin
            @(posedge adc_sampleclk);
            cycles++;
        end
        $display("timeout after %0d cycles, the test sequence did not finish", cycles);
        $display("Errors found");
        $finish;
    end

    initial begin : main
        reset = 1'b1;
        armed_and_ready = 1'b0;
        active = 1'b0;
        adc_datain = 8'h00;
        bus = '0;
        in_stream = 1'b0;
        errors = 0;
        checks = 0;
        stream_state = 32'd90;
        repeat (2) @(posedge adc_sampleclk);
        reset <= 1'b0;

        check_reset_values();
        for (int i = 0; i < num_cases; i++)
            run_case(i);
        repeat (4) @(posedge adc_sampleclk);

        $display("%0d checks, %0d errors", checks, errors);
        if (errors == 0)
            $display("No errors");
        else
            $display("Errors found");
        $finish;
    end

endmodule
